//--- Makefile
TOP = asym_fifo_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module $(TOP) -f asym_fifo.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- asym_fifo.f
common/asym_fifo_pkg.sv
fifo_ctl/fifo_ctl.sv
hw/subword_packer.sv
hw/word_ram.sv
hw/asym_fifo_top.sv
tests/tb_clock_gen.sv
tests/asym_fifo_tb.sv

//--- common/asym_fifo_pkg.sv
package asym_fifo_pkg;

	// ------------------------------------------------------------
	// Data path widths
	// ------------------------------------------------------------
	localparam int SUB_W         = 4;                       // Narrow push-side subword
	localparam int WORD_W        = 16;                      // RAM and pop-side word
	localparam int SUBS_PER_WORD = WORD_W / SUB_W;          // Subwords packed into one word
	localparam int SLOT_W        = $clog2(SUBS_PER_WORD);   // Slot index inside a word
	localparam int LAST_SLOT     = SUBS_PER_WORD - 1;       // Slot that completes a word

	// ------------------------------------------------------------
	// Storage and occupancy
	// ------------------------------------------------------------
	localparam int DEPTH  = 8;                   // Words held in the RAM
	localparam int ADDR_W = $clog2(DEPTH);       // RAM address width
	localparam int CNT_W  = $clog2(DEPTH + 1);   // Count must reach DEPTH itself

	// Flag thresholds in words
	localparam int AE_LVL = 2;                   // Almost empty at or below this
	localparam int AF_LVL = 2;                   // Almost full within this of full
	localparam int HF_CNT = DEPTH / 2;           // Half full threshold
	localparam int AF_CNT = DEPTH - AF_LVL;      // Almost full threshold

	// ------------------------------------------------------------
	// Word container
	// ------------------------------------------------------------
	// The packer builds a word one subword at a time
	// The RAM and the reader only ever see the flat word
	// sub[0] sits in the top nibble so the first pushed subword is the MSB
	typedef union packed
	{
		logic [WORD_W-1:0]                   word;   // RAM and data_out view
		logic [0:SUBS_PER_WORD-1][SUB_W-1:0] sub;    // Packer view
	} word_u;

endpackage

//--- fifo_ctl/fifo_ctl.sv
`timescale 1ns/10ps

module fifo_ctl import asym_fifo_pkg::*;
(
	input  logic              clk_push,
	input  logic              rst_n,
	input  logic              pop_req_n,      // Pop request, active low
	input  logic              word_ready,     // Packer offers a finished word
	input  logic              last_slot,      // Packer hold register at last slot
	output logic              wr_en,          // RAM write strobe, also accept to packer
	output logic [ADDR_W-1:0] wr_addr,
	output logic [ADDR_W-1:0] rd_addr,
	output logic              empty,
	output logic              almost_empty,
	output logic              half_full,
	output logic              almost_full,
	output logic              ram_full,
	output logic              push_full,      // RAM full and hold register at last slot
	output logic              push_error,     // Overrun pulse
	output logic              pop_error       // Underrun pulse
);

	logic [ADDR_W-1:0] wr_ptr;    // Next RAM entry to write
	logic [ADDR_W-1:0] rd_ptr;    // Head of the FIFO
	logic [CNT_W-1:0]  count;     // Words currently in the RAM
	logic              rd_en;     // Pop that actually removes a word

	// ------------------------------------------------------------
	// Write and read qualification
	// ------------------------------------------------------------
	// A word is only taken when the RAM has room
	// A pop in the same cycle does not free a slot early
	assign wr_en = word_ready & ~ram_full;
	assign rd_en = ~pop_req_n & ~empty;   // Pop on empty is ignored

	assign wr_addr = wr_ptr;
	assign rd_addr = rd_ptr;   // data_out follows this combinationally

	// ------------------------------------------------------------
	// Pointers
	// ------------------------------------------------------------
	// DEPTH is a power of two so the pointers wrap on their own
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;   // Advance past the written word
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;   // Expose the next word
		end
	end

	// Occupancy count
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else
		begin
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;   // Write only
				2'b01:   count <= count - 1'b1;   // Pop only
				default: count <= count;          // Both or neither
			endcase
		end
	end

	// ------------------------------------------------------------
	// Level flags
	// ------------------------------------------------------------
	// All decoded from the registered count
	assign empty        = (count == '0);
	assign almost_empty = (count <= CNT_W'(AE_LVL));
	assign half_full    = (count >= CNT_W'(HF_CNT));
	assign almost_full  = (count >= CNT_W'(AF_CNT));
	assign ram_full     = (count == CNT_W'(DEPTH));

	// Completed words now have nowhere to wait
	assign push_full = ram_full & last_slot;

	// ------------------------------------------------------------
	// Error pulses
	// ------------------------------------------------------------
	// Registered so each lasts exactly the cycle after the refused request
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			push_error <= 1'b0;
			pop_error  <= 1'b0;
		end
		else
		begin
			push_error <= word_ready & ram_full;   // Word offered but RAM full
			pop_error  <= ~pop_req_n & empty;      // Pop on an empty FIFO
		end
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	// Pointer distance matches the occupancy, full brings both pointers together
	a_ptr_cnt: assert property (@(posedge clk_push) disable iff (!rst_n)
		(wr_ptr - rd_ptr) == count[ADDR_W-1:0]);

	// Occupancy stays within the RAM across every write and pop
	a_cnt_range: assert property (@(posedge clk_push) disable iff (!rst_n)
		count <= CNT_W'(DEPTH));

endmodule

//--- hw/asym_fifo_top.sv
`timescale 1ns/10ps

module asym_fifo_top import asym_fifo_pkg::*;
(
	input  logic              clk_push,
	input  logic              rst_n,
	input  logic              push_req_n,
	input  logic              flush_n,
	input  logic              pop_req_n,
	input  logic [SUB_W-1:0]  data_in,        // 4-bit subword in
	output logic [WORD_W-1:0] data_out,       // 16-bit word out
	output logic              empty,
	output logic              almost_empty,
	output logic              half_full,
	output logic              almost_full,
	output logic              ram_full,
	output logic              push_full,
	output logic              part_wd,
	output logic              push_error,
	output logic              pop_error
);

	// Packer to control and RAM
	logic              word_ready;
	logic              last_slot;
	word_u             wr_word;
	// Control to packer and RAM
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;

	// ------------------------------------------------------------
	// Push side packing
	// ------------------------------------------------------------
	subword_packer u_packer (
		.clk_push   (clk_push),
		.rst_n      (rst_n),
		.push_req_n (push_req_n),
		.flush_n    (flush_n),
		.data_in    (data_in),
		.wr_en      (wr_en),
		.word_ready (word_ready),
		.last_slot  (last_slot),
		.part_wd    (part_wd),
		.wr_word    (wr_word)
	);

	// Pointers, count, flags and errors
	fifo_ctl u_ctl (
		.clk_push     (clk_push),
		.rst_n        (rst_n),
		.pop_req_n    (pop_req_n),
		.word_ready   (word_ready),
		.last_slot    (last_slot),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.rd_addr      (rd_addr),
		.empty        (empty),
		.almost_empty (almost_empty),
		.half_full    (half_full),
		.almost_full  (almost_full),
		.ram_full     (ram_full),
		.push_full    (push_full),
		.push_error   (push_error),
		.pop_error    (pop_error)
	);

	// Word storage, head word drives data_out directly
	word_ram u_ram (
		.clk_push (clk_push),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_word  (wr_word),
		.rd_addr  (rd_addr),
		.rd_word  (data_out)
	);

endmodule

//--- hw/subword_packer.sv
`timescale 1ns/10ps

module subword_packer import asym_fifo_pkg::*;
(
	input  logic             clk_push,
	input  logic             rst_n,
	input  logic             push_req_n,    // Subword push, active low
	input  logic             flush_n,       // Write out a partial word, active low
	input  logic [SUB_W-1:0] data_in,
	input  logic             wr_en,         // Control block took the word
	output logic             word_ready,    // Word offered to control
	output logic             last_slot,     // Next subword completes the word
	output logic             part_wd,       // Hold register has subwords in it
	output word_u            wr_word        // Assembled word toward the RAM
);

	logic [SLOT_W-1:0] slot;              // Position of the next subword
	logic [SUB_W-1:0]  hold [LAST_SLOT];  // Subwords waiting for the rest of the word
	logic              push;
	logic              flush;
	logic              take_sub;          // Subword goes into the hold register

	assign push  = ~push_req_n;
	assign flush = ~flush_n;

	assign last_slot = (slot == SLOT_W'(LAST_SLOT));

	// ------------------------------------------------------------
	// Word offer
	// ------------------------------------------------------------
	// Flush wins over push and data_in is dropped that cycle
	// A flush with nothing held offers nothing
	assign word_ready = flush ? part_wd : (push & last_slot);

	// Slots below the last are always taken, no RAM room needed
	assign take_sub = push & ~flush & ~last_slot;

	// Build the outgoing word
	always_comb
	begin
		for (int i = 0; i < LAST_SLOT; i++)
		begin
			if (i < int'(slot))
				wr_word.sub[i] = hold[i];   // Filled slot
			else
				wr_word.sub[i] = '0;        // Zero fill for a partial word
		end
		// Last slot comes straight from the input on a full word
		wr_word.sub[LAST_SLOT] = flush ? '0 : data_in;
	end

	// ------------------------------------------------------------
	// Hold register
	// ------------------------------------------------------------
	// Stale entries are masked by the slot on the way out
	always_ff @(posedge clk_push)
	begin
		if (take_sub)
			hold[slot] <= data_in;
	end

	// Slot counter and partial word flag
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot    <= '0;
			part_wd <= 1'b0;
		end
		else if (wr_en)
		begin
			// Word written, start a fresh one
			slot    <= '0;
			part_wd <= 1'b0;
		end
		else if (take_sub)
		begin
			slot    <= slot + 1'b1;
			part_wd <= 1'b1;   // Word still incomplete
		end
		// Refused last-slot push or refused flush keeps everything
	end

	// ------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------
	// Partial word flag is high exactly while subwords are held
	a_part_slot: assert property (@(posedge clk_push) disable iff (!rst_n)
		part_wd == (slot != '0));

endmodule

//--- hw/word_ram.sv
`timescale 1ns/10ps

module word_ram import asym_fifo_pkg::*;
(
	input  logic              clk_push,
	input  logic              wr_en,      // Write strobe from control
	input  logic [ADDR_W-1:0] wr_addr,
	input  word_u             wr_word,    // Packed word from the packer
	input  logic [ADDR_W-1:0] rd_addr,
	output logic [WORD_W-1:0] rd_word     // Head word toward data_out
);

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	// Contents are undefined until written
	logic [WORD_W-1:0] mem [DEPTH];

	// Registered write port
	always_ff @(posedge clk_push)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_word.word;   // Flat word view
	end

	// Combinational read so the head word shows without a pop
	assign rd_word = mem[rd_addr];

endmodule

//--- tests/asym_fifo_tb.sv
`timescale 1ns/10ps

module asym_fifo_tb import asym_fifo_pkg::*;
();

	// Operation codes in the vector file
	localparam int OP_IDLE  = 0;
	localparam int OP_PUSH  = 1;
	localparam int OP_FLUSH = 2;
	localparam int OP_POP   = 3;
	localparam int OP_BOTH  = 4;   // Push and pop in the same cycle

	localparam string VEC_FILE = "tests/asym_fifo_vectors.txt";

	logic              clk_push;
	logic              rst_n;
	logic              push_req_n;
	logic              flush_n;
	logic              pop_req_n;
	logic [SUB_W-1:0]  data_in;
	logic [WORD_W-1:0] data_out;
	logic [8:0]        flags;        // empty down to pop_error, same order as the file

	// Vector columns, one entry per line
	int                tst_q  [$];
	int                op_q   [$];
	logic [SUB_W-1:0]  din_q  [$];
	logic [WORD_W-1:0] dout_q [$];
	logic [8:0]        flg_q  [$];

	string flag_names [9] = '{"empty", "almost_empty", "half_full", "almost_full",
		"ram_full", "push_full", "part_wd", "push_error", "pop_error"};

	int checks      = 0;
	int fails       = 0;
	int test_fails  = 0;      // Mismatches inside the current test
	int cycles      = 0;
	int cycle_limit = 1000;   // Replaced once the vector count is known
	bit load_ok;

	// ------------------------------------------------------------
	// Clock, reset and DUT
	// ------------------------------------------------------------
	tb_clock_gen u_clk (
		.clk_push (clk_push),
		.rst_n    (rst_n)
	);

	asym_fifo_top uut (
		.clk_push     (clk_push),
		.rst_n        (rst_n),
		.push_req_n   (push_req_n),
		.flush_n      (flush_n),
		.pop_req_n    (pop_req_n),
		.data_in      (data_in),
		.data_out     (data_out),
		.empty        (flags[8]),
		.almost_empty (flags[7]),
		.half_full    (flags[6]),
		.almost_full  (flags[5]),
		.ram_full     (flags[4]),
		.push_full    (flags[3]),
		.part_wd      (flags[2]),
		.push_error   (flags[1]),
		.pop_error    (flags[0])
	);

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	// Comment and blank lines fail the scan and are skipped
	task automatic load_vectors(output bit ok);
		int                fd;
		int                tst;
		int                op;
		logic [SUB_W-1:0]  din;
		logic [WORD_W-1:0] dout;
		logic [8:0]        flg;
		string             line;
		ok = 1'b0;
		fd = $fopen(VEC_FILE, "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd) > 0)
			begin
				if ($sscanf(line, "%d %d %h %h %b", tst, op, din, dout, flg) == 5)
				begin
					tst_q.push_back(tst);
					op_q.push_back(op);
					din_q.push_back(din);
					dout_q.push_back(dout);
					flg_q.push_back(flg);
				end
			end
			$fclose(fd);
			ok = (op_q.size() > 0);
		end
	endtask

	task automatic drive_op(int op, logic [SUB_W-1:0] din);
		push_req_n = !(op == OP_PUSH || op == OP_BOTH);   // Active low requests
		flush_n    = !(op == OP_FLUSH);
		pop_req_n  = !(op == OP_POP || op == OP_BOTH);
		data_in    = din;
	endtask

	task automatic check_value(string name, logic [WORD_W-1:0] exp, logic [WORD_W-1:0] act);
		checks++;
		if (act !== exp)
		begin
			fails++;
			test_fails++;
			$display("[FAIL] t=%0d ns %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// The head word is only defined once something was written
	task automatic check_line(int k);
		if (!flg_q[k][8])
			check_value("data_out", dout_q[k], data_out);
		for (int i = 0; i < 9; i++)
			check_value(flag_names[i], WORD_W'(flg_q[k][8-i]), WORD_W'(flags[8-i]));
	endtask

	// One vector line per clock, outputs sampled 1 ns before the next edge
	task automatic run_vectors();
		int n;
		n = op_q.size();
		wait (rst_n === 1'b1);   // Released 1 ns after a rising edge
		drive_op(op_q[0], din_q[0]);
		for (int k = 0; k < n; k++)
		begin
			@(posedge clk_push);   // This edge applies line k
			#1;
			if (k + 1 < n)
				drive_op(op_q[k+1], din_q[k+1]);
			else
				drive_op(OP_IDLE, '0);
			#8;
			check_line(k);
			if (k + 1 == n || tst_q[k+1] != tst_q[k])
			begin
				$display("Test %0d done, %0d mismatches", tst_q[k], test_fails);
				test_fails = 0;
			end
		end
	endtask

	// ------------------------------------------------------------
	// Run control
	// ------------------------------------------------------------
	always @(posedge clk_push)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the vector run never finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		push_req_n = 1'b1;
		flush_n    = 1'b1;
		pop_req_n  = 1'b1;
		data_in    = '0;
		load_vectors(load_ok);
		if (!load_ok)
		begin
			$display("No usable vectors could be read from %s", VEC_FILE);
			$display("TEST RESULT: FAIL");
		end
		else
		begin
			cycle_limit = 4 * op_q.size() + 50;
			run_vectors();
			$display("Checks %0d passed, %0d failed", checks - fails, fails);
			if (fails == 0)
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tests/asym_fifo_vectors.txt
# test op data data_out flags with op 0 idle 1 push 2 flush 3 pop 4 push and pop
# flag bits from left are empty almost_empty half_full almost_full ram_full push_full part_wd push_error pop_error
# data_out is not checked on lines that expect empty
1 0 0 0000 110000000
1 0 0 0000 110000000
2 1 a 0000 110000100
2 1 b 0000 110000100
2 1 c 0000 110000100
2 1 d abcd 010000000
2 1 1 abcd 010000100
2 1 2 abcd 010000100
2 1 3 abcd 010000100
2 1 4 abcd 010000000
2 3 0 1234 010000000
2 3 0 0000 110000000
3 1 5 0000 110000100
3 1 6 0000 110000100
3 2 f 5600 010000000
3 3 0 0000 110000000
3 2 0 0000 110000000
4 1 1 0000 110000100
4 1 1 0000 110000100
4 1 1 0000 110000100
4 1 1 1111 010000000
4 1 2 1111 010000100
4 1 2 1111 010000100
4 1 2 1111 010000100
4 1 2 1111 010000000
4 1 3 1111 010000100
4 1 3 1111 010000100
4 1 3 1111 010000100
4 1 3 1111 000000000
4 1 4 1111 000000100
4 1 4 1111 000000100
4 1 4 1111 000000100
4 1 4 1111 001000000
4 1 5 1111 001000100
4 1 5 1111 001000100
4 1 5 1111 001000100
4 1 5 1111 001000000
4 1 6 1111 001000100
4 1 6 1111 001000100
4 1 6 1111 001000100
4 1 6 1111 001100000
4 1 7 1111 001100100
4 1 7 1111 001100100
4 1 7 1111 001100100
4 1 7 1111 001100000
4 1 8 1111 001100100
4 1 8 1111 001100100
4 1 8 1111 001100100
4 1 8 1111 001110000
5 1 9 1111 001110100
5 1 a 1111 001110100
5 1 b 1111 001111100
5 1 c 1111 001111110
5 0 0 1111 001111100
5 3 0 2222 001100100
5 1 c 2222 001110000
6 3 0 3333 001100000
6 3 0 4444 001100000
6 3 0 5555 001000000
6 3 0 6666 001000000
6 3 0 7777 000000000
6 3 0 8888 010000000
6 3 0 9abc 010000000
6 3 0 0000 110000000
6 3 0 0000 110000001
6 0 0 0000 110000000
6 1 d 0000 110000100
6 1 e 0000 110000100
6 1 f 0000 110000100
6 1 0 def0 010000000
6 1 1 def0 010000100
6 1 2 def0 010000100
6 1 3 def0 010000100
6 4 4 1234 010000000
6 3 0 0000 110000000

//--- tests/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
	output logic clk_push,
	output logic rst_n
);

	// 10 ns period, first rising edge at 5 ns
	initial
	begin
		clk_push = 1'b0;
		forever
			#5 clk_push = ~clk_push;
	end

	// Reset held over five rising edges, released just after the fifth
	initial
	begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk_push);
		#1 rst_n = 1'b1;
	end

endmodule
